//--- hdl/lsu_pkg.sv
// Load/store unit package with the bus widths, access types and stage payload structs
`default_nettype none

package lsu_pkg;

  //////////////////////////////////////////////////
  // Widths that carry a meaning
  //////////////////////////////////////////////////

  // Byte address as seen by the core and the bus
  typedef logic [31:0] addr_t;
  // One data word on either side
  typedef logic [31:0] data_t;
  // One enable per byte lane of a word
  typedef logic [3:0]  be_t;

  // Access size of a load or store
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  // The bus never has more than this many transactions in flight
  localparam int unsigned MAX_OUTSTANDING = 2;

  //////////////////////////////////////////////////
  // Payload structs
  //////////////////////////////////////////////////

  // Request strobed in by the execute stage
  typedef struct packed {
    logic      we;
    lsu_size_e size;
    logic      sign_ext;
    addr_t     addr;
    data_t     wdata;
  } lsu_req_t;

  // Address phase of one bus transaction, addr is always word aligned
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
  } obi_req_t;

  // Per-transaction info that follows a granted request to the response stage
  typedef struct packed {
    logic       is_load;
    lsu_size_e  size;
    logic       sign_ext;
    logic [1:0] offset;
    logic       split;
    logic       second;
  } lsu_txn_t;

  // Finished result back to the core
  typedef struct packed {
    data_t rdata;
  } lsu_resp_t;

endpackage

`default_nettype wire

//--- hdl/lsu_align.sv
// Align stage that registers a core request and cuts it into one or two word-aligned bus requests
`default_nettype none
`timescale 1ns/100ps

module lsu_align (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               lsu_req_valid_i,
  input  wire lsu_pkg::lsu_req_t  lsu_req_i,
  input  wire logic               align_ready_i,
  output logic                    align_valid_o,
  output lsu_pkg::obi_req_t       align_req_o,
  output lsu_pkg::lsu_txn_t       align_txn_o
);

  import lsu_pkg::*;

  // Which half of the access is on offer
  typedef enum logic [1:0] {
    ALIGN_IDLE,
    ALIGN_FIRST,
    ALIGN_SECOND
  } align_state_e;

  align_state_e state_q;
  lsu_req_t     req_q;
  logic [1:0]   offset;
  logic         split;
  be_t          be_base;
  logic [7:0]   be_wide;
  logic [63:0]  wdata_wide;
  addr_t        addr_first;

  //////////////////////////////////////////////////
  // State and request register
  //////////////////////////////////////////////////

  // Request fields stay put for both halves of the access
  always_ff @(posedge clk) begin
    if (lsu_req_valid_i) begin
      req_q <= lsu_req_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALIGN_IDLE;
    end else begin
      case (state_q)
        ALIGN_IDLE: begin
          // The core only strobes while the unit is not busy
          if (lsu_req_valid_i) begin
            state_q <= ALIGN_FIRST;
          end
        end
        ALIGN_FIRST: begin
          if (align_ready_i) begin
            state_q <= split ? ALIGN_SECOND : ALIGN_IDLE;
          end
        end
        ALIGN_SECOND: begin
          if (align_ready_i) begin
            state_q <= ALIGN_IDLE;
          end
        end
        default: state_q <= ALIGN_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Split detection and lane shifting
  //////////////////////////////////////////////////

  always_comb begin
    offset = req_q.addr[1:0];
    // A word crosses at any nonzero offset, a half only when it starts in the last lane
    case (req_q.size)
      LSU_HALF: begin
        split   = (offset == 2'd3);
        be_base = 4'b0011;
      end
      LSU_WORD: begin
        split   = (offset != 2'd0);
        be_base = 4'b1111;
      end
      default: begin
        split   = 1'b0;
        be_base = 4'b0001;
      end
    endcase
    // Shift over two words so the upper half spills into the next one
    be_wide    = {4'b0000, be_base} << offset;
    wdata_wide = {32'd0, req_q.wdata} << {offset, 3'b000};
    addr_first = {req_q.addr[31:2], 2'b00};
  end

  // Offer the half selected by the state machine
  always_comb begin
    align_valid_o = (state_q != ALIGN_IDLE);
    align_req_o.we = req_q.we;
    if (state_q == ALIGN_SECOND) begin
      align_req_o.addr  = addr_first + 32'd4;
      align_req_o.be    = be_wide[7:4];
      align_req_o.wdata = wdata_wide[63:32];
    end else begin
      align_req_o.addr  = addr_first;
      align_req_o.be    = be_wide[3:0];
      align_req_o.wdata = wdata_wide[31:0];
    end
    align_txn_o.is_load  = !req_q.we;
    align_txn_o.size     = req_q.size;
    align_txn_o.sign_ext = req_q.sign_ext;
    align_txn_o.offset   = offset;
    align_txn_o.split    = split;
    align_txn_o.second   = (state_q == ALIGN_SECOND);
  end

endmodule

`default_nettype wire

//--- hdl/lsu_obi_ctrl.sv
// Bus control stage that issues requests on the bus, waits for grant and counts open transactions
`default_nettype none
`timescale 1ns/100ps

module lsu_obi_ctrl (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               align_valid_i,
  input  wire lsu_pkg::obi_req_t  align_req_i,
  input  wire lsu_pkg::lsu_txn_t  align_txn_i,
  output logic                    align_ready_o,
  input  wire logic               obi_gnt_i,
  input  wire logic               obi_rvalid_i,
  output logic                    obi_req_o,
  output lsu_pkg::obi_req_t       obi_req_payload_o,
  output logic                    txn_push_o,
  output lsu_pkg::lsu_txn_t       txn_o,
  output logic [1:0]              cnt_o
);

  import lsu_pkg::*;

  logic [1:0] cnt_q;
  logic       cnt_room;
  logic       count_up;
  logic       count_down;

  //////////////////////////////////////////////////
  // Address phase
  //////////////////////////////////////////////////

  // No new request while the response side already waits on the maximum
  assign cnt_room = (cnt_q < 2'(MAX_OUTSTANDING));

  // The align stage holds its offer until taken, so the payload stays put
  // through a grant stall
  assign obi_req_o         = align_valid_i && cnt_room;
  assign obi_req_payload_o = align_req_i;

  // A transaction is accepted in the cycle where req and gnt meet
  assign count_up      = obi_req_o && obi_gnt_i;
  assign align_ready_o = count_up;

  // Hand the transaction info to the response queue on every grant
  assign txn_push_o = count_up;
  assign txn_o      = align_txn_i;

  //////////////////////////////////////////////////
  // Outstanding count
  //////////////////////////////////////////////////

  // Each rvalid retires the oldest open transaction
  assign count_down = obi_rvalid_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= 2'd0;
    end else begin
      // Grant and rvalid in the same cycle leave the count as it is
      if (count_up && !count_down) begin
        cnt_q <= cnt_q + 2'd1;
      end else if (!count_up && count_down) begin
        cnt_q <= cnt_q - 2'd1;
      end
    end
  end

  assign cnt_o = cnt_q;

endmodule

`default_nettype wire

//--- hdl/lsu_resp.sv
// Response stage that collects bus read data, merges split halves and extends the load result
`default_nettype none
`timescale 1ns/100ps

module lsu_resp (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               txn_push_i,
  input  wire lsu_pkg::lsu_txn_t  txn_i,
  input  wire logic               obi_rvalid_i,
  input  wire lsu_pkg::data_t     obi_rdata_i,
  output logic                    lsu_resp_valid_o,
  output lsu_pkg::lsu_resp_t      lsu_resp_o
);

  import lsu_pkg::*;

  lsu_txn_t    q_mem [2];
  logic        wr_ptr_q;
  logic        rd_ptr_q;
  lsu_txn_t    head;
  data_t       lo_data_q;
  logic [63:0] merged;
  data_t       shifted;
  data_t       result;
  logic        last_half;
  logic        resp_valid_q;
  lsu_resp_t   resp_q;

  //////////////////////////////////////////////////
  // Transaction queue
  //////////////////////////////////////////////////

  // Two entries cover the most the bus control stage lets out
  always_ff @(posedge clk) begin
    if (txn_push_i) begin
      q_mem[wr_ptr_q] <= txn_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end else begin
      if (txn_push_i) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      // Responses come back in order, so each rvalid belongs to the head
      if (obi_rvalid_i) begin
        rd_ptr_q <= !rd_ptr_q;
      end
    end
  end

  assign head = q_mem[rd_ptr_q];

  //////////////////////////////////////////////////
  // Merge and extend
  //////////////////////////////////////////////////

  // The first half of a split only gets parked here
  assign last_half = !head.split || head.second;

  always_ff @(posedge clk) begin
    if (obi_rvalid_i && !last_half) begin
      lo_data_q <= obi_rdata_i;
    end
  end

  always_comb begin
    // Lay the two words side by side, then drop the lanes below the offset
    merged  = head.split ? {obi_rdata_i, lo_data_q} : {32'd0, obi_rdata_i};
    shifted = 32'(merged >> {head.offset, 3'b000});
    case (head.size)
      LSU_BYTE: result = {{24{head.sign_ext & shifted[7]}}, shifted[7:0]};
      LSU_HALF: result = {{16{head.sign_ext & shifted[15]}}, shifted[15:0]};
      default:  result = shifted;
    endcase
    // Stores still answer, but with zero data
    if (!head.is_load) begin
      result = 32'd0;
    end
  end

  // Strobe the result one cycle after the last rvalid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= obi_rvalid_i && last_half;
    end
  end

  always_ff @(posedge clk) begin
    if (obi_rvalid_i && last_half) begin
      resp_q.rdata <= result;
    end
  end

  assign lsu_resp_valid_o = resp_valid_q;
  assign lsu_resp_o       = resp_q;

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
// Load/store unit top that chains the align, bus control and response stages
`default_nettype none
`timescale 1ns/100ps

module lsu_top (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire logic               lsu_req_valid_i,
  input  wire lsu_pkg::lsu_req_t  lsu_req_i,
  output logic                    busy_o,
  output logic                    lsu_resp_valid_o,
  output lsu_pkg::lsu_resp_t      lsu_resp_o,
  output logic                    obi_req_o,
  output lsu_pkg::obi_req_t       obi_req_payload_o,
  input  wire logic               obi_gnt_i,
  input  wire logic               obi_rvalid_i,
  input  wire lsu_pkg::data_t     obi_rdata_i
);

  import lsu_pkg::*;

  logic       align_valid;
  logic       align_ready;
  obi_req_t   align_req;
  lsu_txn_t   align_txn;
  logic       txn_push;
  lsu_txn_t   txn_q;
  logic [1:0] cnt;

  lsu_align u_align (
    .clk             (clk),
    .rst_n           (rst_n),
    .lsu_req_valid_i (lsu_req_valid_i),
    .lsu_req_i       (lsu_req_i),
    .align_ready_i   (align_ready),
    .align_valid_o   (align_valid),
    .align_req_o     (align_req),
    .align_txn_o     (align_txn)
  );

  lsu_obi_ctrl u_obi_ctrl (
    .clk               (clk),
    .rst_n             (rst_n),
    .align_valid_i     (align_valid),
    .align_req_i       (align_req),
    .align_txn_i       (align_txn),
    .align_ready_o     (align_ready),
    .obi_gnt_i         (obi_gnt_i),
    .obi_rvalid_i      (obi_rvalid_i),
    .obi_req_o         (obi_req_o),
    .obi_req_payload_o (obi_req_payload_o),
    .txn_push_o        (txn_push),
    .txn_o             (txn_q),
    .cnt_o             (cnt)
  );

  lsu_resp u_resp (
    .clk              (clk),
    .rst_n            (rst_n),
    .txn_push_i       (txn_push),
    .txn_i            (txn_q),
    .obi_rvalid_i     (obi_rvalid_i),
    .obi_rdata_i      (obi_rdata_i),
    .lsu_resp_valid_o (lsu_resp_valid_o),
    .lsu_resp_o       (lsu_resp_o)
  );

  // Busy runs from the cycle after the strobe through the result strobe,
  // the three terms overlap so there is no gap between stages
  assign busy_o = align_valid || (cnt != 2'd0) || lsu_resp_valid_o;

endmodule

`default_nettype wire

//--- tests/lsu_asserts.sv
// Protocol and result assertions for the load/store unit, bound into its top level
`default_nettype none
`timescale 1ns/100ps

module lsu_asserts (
  input wire logic               clk,
  input wire logic               rst_n,
  input wire logic               lsu_req_valid_i,
  input wire logic               busy_i,
  input wire logic               lsu_resp_valid_i,
  input wire lsu_pkg::lsu_resp_t lsu_resp_i,
  input wire logic               obi_req_i,
  input wire lsu_pkg::obi_req_t  obi_req_payload_i,
  input wire logic               obi_gnt_i,
  input wire logic               obi_rvalid_i,
  input wire logic [1:0]         cnt_i
);

  import lsu_pkg::*;

  //////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////

  // Never more transactions in flight than the bus control stage allows
  cnt_max_a: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_i <= 2'(MAX_OUTSTANDING))
    else begin
      tb_lsu.assert_fails++;
      $error("Outstanding count above the limit");
    end

  // Each rvalid must answer a transaction that is still open
  rvalid_open_a: assert property (@(posedge clk) disable iff (!rst_n)
    obi_rvalid_i |-> (cnt_i != 2'd0))
    else begin
      tb_lsu.assert_fails++;
      $error("rvalid with no open transaction");
    end

  no_x_payload_a: assert property (@(posedge clk) disable iff (!rst_n)
    obi_req_i |-> !$isunknown(obi_req_payload_i))
    else begin
      tb_lsu.assert_fails++;
      $error("Unknown bits in the bus payload");
    end

  // A request that is not granted stays up with the same payload
  stall_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (obi_req_i && !obi_gnt_i) |=> (obi_req_i && $stable(obi_req_payload_i)))
    else begin
      tb_lsu.assert_fails++;
      $error("Bus request changed during a grant stall");
    end

  //////////////////////////////////////////////////
  // Core side
  //////////////////////////////////////////////////

  // The first half goes out in the cycle after the strobe
  first_req_a: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_req_valid_i |=> (obi_req_i && busy_i))
    else begin
      tb_lsu.assert_fails++;
      $error("No bus request or busy after the strobe");
    end

  // Busy holds over every open transaction until the result strobe
  busy_cover_a: assert property (@(posedge clk) disable iff (!rst_n)
    (busy_i && !lsu_resp_valid_i) |=> busy_i)
    else begin
      tb_lsu.assert_fails++;
      $error("busy_o dropped before the result strobe");
    end

  // The head of the expected queue in the testbench is the next result
  rdata_a: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_resp_valid_i |-> (lsu_resp_i.rdata == tb_lsu.exp_head))
    else begin
      tb_lsu.assert_fails++;
      $error("Fail t=%0t lsu_resp_o.rdata got %h expected %h",
             $time, lsu_resp_i.rdata, tb_lsu.exp_head);
    end

endmodule

`default_nettype wire

//--- tests/tb_lsu.sv
// Testbench for the load/store unit with a random-stall bus memory and a shadow memory model
`default_nettype none
`timescale 1ns/100ps

module tb_lsu;

  import lsu_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam logic [31:0] SEED = 32'hfe1c;
  // Request counts per test set the watchdog time
  localparam int T1_REQ = 8;
  localparam int T2_REQ = 14;
  localparam int T3_REQ = 14;
  localparam int T4_REQ = 40;
  localparam int T5_REQ = 8;
  localparam int TOTAL_REQ = T1_REQ + T2_REQ + T3_REQ + T4_REQ + T5_REQ;
  localparam int WATCHDOG_NS = (RESET_CYCLES + 200 * TOTAL_REQ) * 8;

  logic clk = 1'b0;
  logic rst_n, req_valid, busy, resp_valid, obi_req, obi_gnt, obi_rvalid;
  lsu_req_t  req;
  lsu_resp_t resp;
  obi_req_t  obi_pay;
  data_t     obi_rdata, exp_head;
  data_t     mem [64];
  data_t     shadow [64];
  data_t     exp_q [$];
  data_t     rsp_data_q [$];
  int        rsp_due_q [$];
  logic [31:0] stim_lfsr, bus_lfsr;
  int assert_fails = 0;
  int check_fails, n_req, resp_seen, cyc, last_due, tests_done;

  lsu_top dut0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .lsu_req_valid_i   (req_valid),
    .lsu_req_i         (req),
    .busy_o            (busy),
    .lsu_resp_valid_o  (resp_valid),
    .lsu_resp_o        (resp),
    .obi_req_o         (obi_req),
    .obi_req_payload_o (obi_pay),
    .obi_gnt_i         (obi_gnt),
    .obi_rvalid_i      (obi_rvalid),
    .obi_rdata_i       (obi_rdata)
  );

  bind lsu_top lsu_asserts u_asserts (
    .clk               (clk),
    .rst_n             (rst_n),
    .lsu_req_valid_i   (lsu_req_valid_i),
    .busy_i            (busy_o),
    .lsu_resp_valid_i  (lsu_resp_valid_o),
    .lsu_resp_i        (lsu_resp_o),
    .obi_req_i         (obi_req_o),
    .obi_req_payload_i (obi_req_payload_o),
    .obi_gnt_i         (obi_gnt_i),
    .obi_rvalid_i      (obi_rvalid_i),
    .cnt_i             (cnt)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////

  // 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit taken
  function automatic int unsigned take_bits(inout logic [31:0] state, input int n);
    int i;
    int unsigned v;
    v = 0;
    for (i = 0; i < n; i++) begin
      state = {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
      v = {v[30:0], state[0]};
    end
    return v;
  endfunction

  // Seed pattern mixes every address bit into every byte
  function automatic data_t fill_word(input int i);
    return (32'(i) * 32'h9e37_79b1) ^ 32'h5ac3_e10f;
  endfunction

  function automatic int size_bytes(input lsu_size_e size);
    return (size == LSU_BYTE) ? 1 : (size == LSU_HALF) ? 2 : 4;
  endfunction

  // Byte-wise little-endian view of the shadow memory that wraps at 256 bytes
  function automatic data_t shadow_load(input addr_t addr, input lsu_size_e size, input logic sx);
    int i;
    int nb;
    addr_t ab;
    data_t v;
    nb = size_bytes(size);
    v = '0;
    for (i = 0; i < nb; i++) begin
      ab = addr + 32'(i);
      v[8*i +: 8] = shadow[ab[7:2]][{ab[1:0], 3'b000} +: 8];
    end
    if (sx && v[8*nb-1]) begin
      for (i = nb; i < 4; i++) begin
        v[8*i +: 8] = 8'hff;
      end
    end
    return v;
  endfunction

  task automatic shadow_store(input addr_t addr, input lsu_size_e size, input data_t wdata);
    int i;
    addr_t ab;
    for (i = 0; i < size_bytes(size); i++) begin
      ab = addr + 32'(i);
      shadow[ab[7:2]][{ab[1:0], 3'b000} +: 8] = wdata[8*i +: 8];
    end
  endtask

  // Strobe one request once the unit is idle and wait for its result
  task automatic access(input logic we, input lsu_size_e size, input logic sx,
                        input addr_t addr, input data_t wdata);
    data_t expv;
    while (busy) begin
      @(posedge clk);
      #1;
    end
    if (we) begin
      shadow_store(addr, size, wdata);
      expv = '0;
    end else begin
      expv = shadow_load(addr, size, sx);
    end
    exp_q.push_back(expv);
    exp_head = exp_q[0];
    req_valid = 1'b1;
    req.we = we;
    req.size = size;
    req.sign_ext = sx;
    req.addr = addr;
    req.wdata = wdata;
    n_req++;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    while (!resp_valid) begin
      @(posedge clk);
      #1;
    end
    // The result is checked at the edge that ends the strobe cycle
    @(posedge clk);
    #1;
    void'(exp_q.pop_front());
    if (exp_q.size() != 0) begin
      exp_head = exp_q[0];
    end
  endtask

  task automatic finish_test(input int num, input string name, input int reqs);
    tests_done++;
    $display("Test %0d %s finished after %0d requests, %0d failures so far",
             num, name, reqs, assert_fails + check_fails);
  endtask

  // Accepts one granted transaction and schedules its in-order response
  task automatic serve(input obi_req_t p);
    int b;
    int due;
    int unsigned v;
    data_t rd;
    rd = mem[p.addr[7:2]];
    for (b = 0; b < 4; b++) begin
      if (p.we && p.be[b]) begin
        mem[p.addr[7:2]][8*b +: 8] = p.wdata[8*b +: 8];
      end
    end
    v = take_bits(bus_lfsr, 1);
    due = cyc + 1 + int'(v);
    if (due <= last_due) begin
      due = last_due + 1;
    end
    last_due = due;
    rsp_due_q.push_back(due);
    rsp_data_q.push_back(p.we ? '0 : rd);
  endtask

  ////////////////////////////////////////////////////
  // Bus memory model
  ////////////////////////////////////////////////////

  initial begin : bus_model
    int i;
    int stall;
    int unsigned v;
    logic armed;
    obi_gnt = 1'b0;
    obi_rvalid = 1'b0;
    obi_rdata = '0;
    bus_lfsr = SEED;
    cyc = 0;
    last_due = 0;
    resp_seen = 0;
    armed = 1'b0;
    stall = 0;
    for (i = 0; i < 64; i++) begin
      mem[i] = fill_word(i);
    end
    forever begin
      @(posedge clk);
      #1;
      cyc++;
      if (resp_valid) begin
        resp_seen++;
      end
      if (rsp_due_q.size() != 0 && rsp_due_q[0] == cyc) begin
        obi_rvalid = 1'b1;
        obi_rdata = rsp_data_q.pop_front();
        void'(rsp_due_q.pop_front());
      end else begin
        obi_rvalid = 1'b0;
        obi_rdata = '0;
      end
      // Request and payload come from registers, so they are settled here
      obi_gnt = 1'b0;
      if (obi_req) begin
        if (!armed) begin
          v = take_bits(bus_lfsr, 2);
          stall = int'(v);
          armed = 1'b1;
        end
        if (stall == 0) begin
          obi_gnt = 1'b1;
          armed = 1'b0;
          serve(obi_pay);
        end else begin
          stall--;
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired: a request was left without a response");
    $display("Done: errors found");
    $finish;
  end

  ////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////

  initial begin : stimulus
    int i;
    int unsigned v;
    int unsigned w;
    addr_t a;
    lsu_size_e sz;
    rst_n = 1'b0;
    req_valid = 1'b0;
    req = '0;
    exp_head = '0;
    stim_lfsr = SEED;
    check_fails = 0;
    n_req = 0;
    tests_done = 0;
    for (i = 0; i < 64; i++) begin
      shadow[i] = fill_word(i);
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    for (i = 0; i < 4; i++) begin
      v = take_bits(stim_lfsr, 32);
      access(1'b1, LSU_WORD, 1'b0, 32'(i * 52), v);
      access(1'b0, LSU_WORD, 1'b0, 32'(i * 52), '0);
    end
    finish_test(1, "aligned word store and load", T1_REQ);
    for (i = 0; i < 8; i++) begin
      access(1'b0, LSU_BYTE, i[0], 32'h40 + 32'(i / 2), '0);
    end
    for (i = 0; i < 6; i++) begin
      access(1'b0, LSU_HALF, i[0], 32'h80 + 32'(i / 2), '0);
    end
    finish_test(2, "byte and half loads at each offset", T2_REQ);
    for (i = 1; i < 4; i++) begin
      access(1'b0, LSU_WORD, 1'b0, 32'hc0 + 32'(i), '0);
    end
    access(1'b0, LSU_HALF, 1'b0, 32'hc7, '0);
    access(1'b0, LSU_HALF, 1'b1, 32'hc7, '0);
    // Split stores that are each read back as the two aligned words they touch
    for (i = 1; i < 4; i++) begin
      a = 32'h90 + 32'(8 * i);
      v = take_bits(stim_lfsr, 32);
      access(1'b1, LSU_WORD, 1'b0, a + 32'(i), v);
      access(1'b0, LSU_WORD, 1'b0, a, '0);
      access(1'b0, LSU_WORD, 1'b0, a + 32'd4, '0);
    end
    finish_test(3, "split loads and stores", T3_REQ);
    for (i = 0; i < T4_REQ; i++) begin
      v = take_bits(stim_lfsr, 2);
      sz = (v == 0) ? LSU_BYTE : (v == 1) ? LSU_HALF : LSU_WORD;
      v = take_bits(stim_lfsr, 10);
      w = take_bits(stim_lfsr, 32);
      access(v[9], sz, v[8], 32'(v[7:0]), w);
    end
    finish_test(4, "random accesses under grant stalls", T4_REQ);
    // Back-to-back split words keep two transactions open
    for (i = 0; i < T5_REQ; i++) begin
      v = take_bits(stim_lfsr, 8);
      w = take_bits(stim_lfsr, 32);
      a = {24'd0, v[7:2], (v[1:0] == 2'd0) ? 2'd1 : v[1:0]};
      access(i[0], LSU_WORD, 1'b0, a, w);
    end
    finish_test(5, "back-to-back split words", T5_REQ);
    if (resp_seen != n_req) begin
      $display("Fail t=%0t responses got %0d expected %0d", $time, resp_seen, n_req);
      check_fails++;
    end
    $display("Summary: %0d tests, %0d requests, %0d responses, %0d errors",
             tests_done, n_req, resp_seen, assert_fails + check_fails);
    if (assert_fails + check_fails == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
hdl/lsu_pkg.sv
hdl/lsu_align.sv
hdl/lsu_obi_ctrl.sv
hdl/lsu_resp.sv
hdl/lsu_top.sv
tests/lsu_asserts.sv
tests/tb_lsu.sv

//--- Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := tb_lsu
FILELIST  := src.f
BUILD_DIR := obj_dir
RUN_ARGS  := +verilator+error+limit+1000
PASS_MSG  := Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run passes only if the pass message shows up as a line of its own
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
